/* src/pipePkg.sv */
package pipePkg;

	// ####################
	// widths
	localparam int dataWidth = 16;
	localparam int regSelWidth = 3; // eight registers
	localparam int axiAddrWidth = 16;
	localparam int axiDataWidth = 32; // loads use the low half
	localparam int axiStrbWidth = axiDataWidth / 8;
	localparam logic [1:0] axiRespOkay = 2'b00;

	// ####################
	// opcodes
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluSlt, aluPassB
	} aluOpT;

	typedef enum logic [1:0] {memNone, memLoad, memStore} memOpT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

	// ####################
	// pipeline bundles
	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		memOpT memOp;
		wbSelT wbSel;
		logic regWrite;
		logic [regSelWidth-1:0] writeReg;
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
		logic [dataWidth-1:0] storeData;
		logic [dataWidth-1:0] pc;
		logic halt;
		logic err;
	} exBundleT;

	typedef struct packed {
		logic valid;
		memOpT memOp;
		wbSelT wbSel;
		logic regWrite;
		logic [regSelWidth-1:0] writeReg;
		logic [dataWidth-1:0] aluOut; // also the memory address
		logic [dataWidth-1:0] storeData;
		logic [dataWidth-1:0] pcAdd2;
		logic halt;
		logic err;
	} exMemBundleT;

	typedef struct packed {
		logic valid;
		wbSelT wbSel;
		logic regWrite;
		logic [regSelWidth-1:0] writeReg;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] loadData;
		logic [dataWidth-1:0] pcAdd2;
		logic halt;
		logic err;
	} memWbBundleT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic [regSelWidth-1:0] writeReg;
		logic [dataWidth-1:0] data;
		logic err;
	} wbPortT;

	// ####################
	// AXI4-Lite
	typedef struct packed {
		logic awvalid;
		logic [axiAddrWidth-1:0] awaddr;
		logic wvalid;
		logic [axiDataWidth-1:0] wdata;
		logic [axiStrbWidth-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [axiAddrWidth-1:0] araddr;
		logic rready;
	} axiReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [axiDataWidth-1:0] rdata;
		logic [1:0] rresp;
	} axiRspT;

endpackage

/* src/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
	input pipePkg::exBundleT exIn,
	output pipePkg::exMemBundleT exOut
);
	import pipePkg::*;

	logic [dataWidth-1:0] result;
	logic [3:0] shamt;
	logic sltBit;
	logic badOp;

	assign shamt = exIn.opB[3:0]; // shifts only look at the low nibble
	assign sltBit = $signed(exIn.opA) < $signed(exIn.opB);

	always_comb begin
		result = '0;
		badOp = 1'b0;
		case (exIn.aluOp)
			aluAdd: begin
				result = exIn.opA + exIn.opB;
			end
			aluSub: begin
				result = exIn.opA - exIn.opB;
			end
			aluAnd: begin
				result = exIn.opA & exIn.opB;
			end
			aluOr: begin
				result = exIn.opA | exIn.opB;
			end
			aluXor: begin
				result = exIn.opA ^ exIn.opB;
			end
			aluSll: begin
				result = exIn.opA << shamt;
			end
			aluSrl: begin
				result = exIn.opA >> shamt;
			end
			aluSlt: begin
				result = {{(dataWidth-1){1'b0}}, sltBit};
			end
			aluPassB: begin
				result = exIn.opB;
			end
			default: begin
				badOp = 1'b1; // encoding outside the opcode set
			end
		endcase
	end

	// ####################
	// bundle to EX/MEM
	always_comb begin
		exOut.valid = exIn.valid;
		exOut.memOp = exIn.memOp;
		exOut.wbSel = exIn.wbSel;
		exOut.regWrite = exIn.regWrite;
		exOut.writeReg = exIn.writeReg;
		exOut.aluOut = result;
		exOut.storeData = exIn.storeData;
		exOut.pcAdd2 = exIn.pc + dataWidth'(2); // link value
		exOut.halt = exIn.halt;
		exOut.err = exIn.err | badOp;
	end

endmodule

/* src/exMemReg.sv */
`timescale 1ns/100ps

module exMemReg (
	input logic clk,
	input logic reset,
	input logic dmemStall,
	input pipePkg::exMemBundleT exIn,
	output pipePkg::exMemBundleT exOut,
	output logic halted
);
	import pipePkg::*;

	logic capture;
	logic haltSeen;
	logic errIn;

	// the stage freezes while the data memory is busy
	assign capture = ~dmemStall;

	assign haltSeen = exIn.valid & exIn.halt;

	// errors only count for a live bundle
	assign errIn = exIn.err & exIn.valid;

	always_ff @(posedge clk) begin
		if (capture) begin
			exOut.memOp <= exIn.memOp;
			exOut.wbSel <= exIn.wbSel;
			exOut.regWrite <= exIn.regWrite;
			exOut.writeReg <= exIn.writeReg;
			exOut.aluOut <= exIn.aluOut;
			exOut.storeData <= exIn.storeData;
			exOut.pcAdd2 <= exIn.pcAdd2;
			exOut.halt <= exIn.halt;
			exOut.err <= errIn;
		end

		if (reset) begin
			exOut.valid <= 1'b0;
		end else if (capture) begin
			exOut.valid <= exIn.valid & ~halted; // nothing gets past a halt
		end
	end

	// ####################
	// halt tracking
	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (capture && haltSeen) begin
			halted <= 1'b1; // sticky until reset
		end
	end

endmodule

/* src/memAxiPort.sv */
`timescale 1ns/100ps

module memAxiPort (
	input logic clk,
	input logic reset,
	input pipePkg::exMemBundleT exIn,
	output pipePkg::axiReqT axiReq,
	input pipePkg::axiRspT axiRsp,
	output logic dmemStall,
	output pipePkg::memWbBundleT memOut
);
	import pipePkg::*;

	typedef enum logic [1:0] {idle, addrPhase, respWait} stateT;

	stateT state;
	stateT stateNext;
	logic awDone;
	logic wDone;
	logic isMem;
	logic isStore;
	logic misaligned;
	logic memReq;
	logic awHs;
	logic wHs;
	logic arHs;
	logic addrDone;
	logic respDone;
	logic respErr;

	assign isStore = exIn.memOp == memStore;
	assign isMem = exIn.valid & (isStore | (exIn.memOp == memLoad));
	assign misaligned = isMem & exIn.aluOut[0]; // completes at once, no bus access
	assign memReq = isMem & ~exIn.aluOut[0];

	// ####################
	// AXI master outputs
	always_comb begin
		axiReq = '0;
		axiReq.awaddr = exIn.aluOut;
		axiReq.araddr = exIn.aluOut;
		axiReq.wdata = axiDataWidth'(exIn.storeData); // zero-extended
		axiReq.wstrb = '1;
		if (state == addrPhase) begin
			axiReq.awvalid = isStore & ~awDone;
			axiReq.wvalid = isStore & ~wDone;
			axiReq.arvalid = ~isStore;
		end
		if (state == respWait) begin
			axiReq.bready = isStore;
			axiReq.rready = ~isStore;
		end
	end

	assign awHs = axiReq.awvalid & axiRsp.awready;
	assign wHs = axiReq.wvalid & axiRsp.wready;
	assign arHs = axiReq.arvalid & axiRsp.arready;

	// aw and w may finish in either order
	assign addrDone = isStore ? ((awDone | awHs) & (wDone | wHs)) : arHs;

	assign respDone = (state == respWait) & (isStore ? axiRsp.bvalid : axiRsp.rvalid);
	assign respErr = isStore ? (axiRsp.bresp != axiRespOkay) : (axiRsp.rresp != axiRespOkay);

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (memReq) stateNext = addrPhase;
			end
			addrPhase: begin
				if (addrDone) stateNext = respWait;
			end
			respWait: begin
				if (respDone) stateNext = idle;
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			awDone <= 1'b0;
			wDone <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == addrPhase) begin
				awDone <= awDone | awHs;
				wDone <= wDone | wHs;
			end else begin
				awDone <= 1'b0;
				wDone <= 1'b0;
			end
		end
	end

	// ####################
	// stall and result
	assign dmemStall = memReq & ~respDone;

	always_comb begin
		memOut.valid = exIn.valid & (~isMem | misaligned | respDone);
		memOut.wbSel = exIn.wbSel;
		memOut.regWrite = exIn.regWrite;
		memOut.writeReg = exIn.writeReg;
		memOut.aluOut = exIn.aluOut;
		memOut.loadData = axiRsp.rdata[dataWidth-1:0];
		memOut.pcAdd2 = exIn.pcAdd2;
		memOut.halt = exIn.halt;
		memOut.err = exIn.err | misaligned | (respDone & respErr);
	end

endmodule

/* src/memWbReg.sv */
`timescale 1ns/100ps

module memWbReg (
	input logic clk,
	input logic reset,
	input pipePkg::memWbBundleT memIn,
	output pipePkg::wbPortT wb
);
	import pipePkg::*;

	logic [dataWidth-1:0] wbData;
	logic regWriteOk;

	always_comb begin
		case (memIn.wbSel)
			wbMem: begin
				wbData = memIn.loadData;
			end
			wbLink: begin
				wbData = memIn.pcAdd2; // return address
			end
			default: begin
				wbData = memIn.aluOut;
			end
		endcase
	end

	// a faulted instruction never touches the register file
	assign regWriteOk = memIn.regWrite & ~memIn.err;

	always_ff @(posedge clk) begin
		wb.regWrite <= regWriteOk;
		wb.writeReg <= memIn.writeReg;
		wb.data <= wbData;
		wb.err <= memIn.err;
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= memIn.valid;
		end
	end

endmodule

/* src/backEnd.sv */
`timescale 1ns/100ps

module backEnd (
	input logic clk,
	input logic reset,
	input pipePkg::exBundleT exIn,
	output logic dmemStall,
	output logic halted,
	output pipePkg::axiReqT axiReq,
	input pipePkg::axiRspT axiRsp,
	output pipePkg::wbPortT wb
);
	import pipePkg::*;

	exMemBundleT exResult; // execute -> EX/MEM
	exMemBundleT exMemOut; // EX/MEM -> memory stage
	memWbBundleT memResult; // memory stage -> MEM/WB

	// ####################
	// execute
	aluUnit aluUnit_i (
		.exIn(exIn),
		.exOut(exResult)
	);

	exMemReg exMemReg_i (
		.clk(clk),
		.reset(reset),
		.dmemStall(dmemStall),
		.exIn(exResult),
		.exOut(exMemOut),
		.halted(halted)
	);

	// ####################
	// memory and writeback
	memAxiPort memAxiPort_i (
		.clk(clk),
		.reset(reset),
		.exIn(exMemOut),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.dmemStall(dmemStall),
		.memOut(memResult)
	);

	memWbReg memWbReg_i (
		.clk(clk),
		.reset(reset),
		.memIn(memResult),
		.wb(wb)
	);

endmodule

/* verif/axiMemModel.sv */
`timescale 1ns/100ps

module axiMemModel (
	input logic clk,
	input logic reset,
	input pipePkg::axiReqT axiReq,
	output pipePkg::axiRspT axiRsp
);
	import pipePkg::*;

	logic [dataWidth-1:0] mem [0:255]; // 16-bit words indexed by byte address bits 8:1
	axiRspT rsp = '0;
	logic awGot;
	logic wGot;
	logic arGot;
	logic [axiAddrWidth-1:0] wrAddr;
	logic [axiAddrWidth-1:0] rdAddr;
	logic [dataWidth-1:0] wrData;
	logic [1:0] wrStrb;
	int awWait;
	int wWait;
	int arWait;
	int bWait;
	int rWait;

	assign axiRsp = rsp;

	always @(posedge clk) begin
		if (reset) begin
			rsp <= '0;
			awGot <= 1'b0;
			wGot <= 1'b0;
			arGot <= 1'b0;
			awWait <= $urandom_range(0, 5);
			wWait <= $urandom_range(0, 5);
			arWait <= $urandom_range(0, 5);
			bWait <= $urandom_range(0, 5);
			rWait <= $urandom_range(0, 5);
			for (int i = 0; i < 256; i++) begin
				mem[i] <= '0;
			end
		end else begin
			rsp.awready <= 1'b0; // readies pulse for one cycle
			rsp.wready <= 1'b0;
			rsp.arready <= 1'b0;

			// ####################
			// write channels
			if (axiReq.awvalid && rsp.awready) begin
				wrAddr <= axiReq.awaddr;
				awGot <= 1'b1;
				awWait <= $urandom_range(0, 5);
			end else if (axiReq.awvalid && !awGot) begin
				if (awWait == 0) rsp.awready <= 1'b1;
				else awWait <= awWait - 1;
			end
			if (axiReq.wvalid && rsp.wready) begin
				wrData <= axiReq.wdata[dataWidth-1:0];
				wrStrb <= axiReq.wstrb[1:0]; // byte lanes of the low half
				wGot <= 1'b1;
				wWait <= $urandom_range(0, 5);
			end else if (axiReq.wvalid && !wGot) begin
				if (wWait == 0) rsp.wready <= 1'b1;
				else wWait <= wWait - 1;
			end
			if (rsp.bvalid && axiReq.bready) begin
				rsp.bvalid <= 1'b0;
				awGot <= 1'b0;
				wGot <= 1'b0;
				bWait <= $urandom_range(0, 5);
			end else if (awGot && wGot && !rsp.bvalid) begin
				if (bWait == 0) begin
					rsp.bvalid <= 1'b1;
					rsp.bresp <= axiRespOkay;
					if (wrStrb[0]) mem[wrAddr[8:1]][7:0] <= wrData[7:0];
					if (wrStrb[1]) mem[wrAddr[8:1]][15:8] <= wrData[15:8];
				end else begin
					bWait <= bWait - 1;
				end
			end

			// ####################
			// read channels
			if (axiReq.arvalid && rsp.arready) begin
				rdAddr <= axiReq.araddr;
				arGot <= 1'b1;
				arWait <= $urandom_range(0, 5);
			end else if (axiReq.arvalid && !arGot) begin
				if (arWait == 0) rsp.arready <= 1'b1;
				else arWait <= arWait - 1;
			end
			if (rsp.rvalid && axiReq.rready) begin
				rsp.rvalid <= 1'b0;
				arGot <= 1'b0;
				rWait <= $urandom_range(0, 5);
			end else if (arGot && !rsp.rvalid) begin
				if (rWait == 0) begin
					rsp.rvalid <= 1'b1;
					rsp.rresp <= axiRespOkay;
					rsp.rdata <= axiDataWidth'(mem[rdAddr[8:1]]);
				end else begin
					rWait <= rWait - 1;
				end
			end
		end
	end

endmodule

/* verif/backEndTb.sv */
`timescale 1ns/100ps

module backEndTb;
	import pipePkg::*;

	localparam int patCols = 12; // words per pattern line
	localparam int maxLines = 64;
	localparam int stallLimit = 200;
	localparam int drainLimit = 1000;
	localparam int quietCycles = 20;

	typedef struct packed {
		logic [dataWidth-1:0] data;
		logic err;
		logic regWrite;
		logic [regSelWidth-1:0] writeReg;
		logic isMem; // aligned load or store, goes out on the bus
	} expT;

	logic clk;
	logic reset;
	exBundleT exIn;
	logic dmemStall;
	logic halted;
	axiReqT axiReq;
	axiRspT axiRsp;
	wbPortT wb;

	logic [dataWidth-1:0] patMem [0:patCols*maxLines-1];
	expT expArr [0:maxLines-1];
	int issued = 0; // written by the driver
	int memIssued = 0;
	int retired = 0; // written by the monitor
	int memRetired = 0;

	backEnd dut_i (
		.clk(clk),
		.reset(reset),
		.exIn(exIn),
		.dmemStall(dmemStall),
		.halted(halted),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.wb(wb)
	);

	axiMemModel memModel_i (
		.clk(clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ####################
	// checking helpers
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		if (got !== exp)
			failRun($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic checkReg(input string name, input logic [regSelWidth-1:0] got,
			input logic [regSelWidth-1:0] exp);
		if (got !== exp)
			failRun($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	function automatic logic busActive(input axiReqT req);
		return req.awvalid | req.wvalid | req.arvalid | req.bready | req.rready;
	endfunction

	// ####################
	// pattern decoding
	function automatic exBundleT makeBundle(input int line);
		exBundleT b;
		int base;
		base = line * patCols;
		b.valid = 1'b1;
		b.aluOp = aluOpT'(patMem[base][3:0]);
		b.memOp = memOpT'(patMem[base+1][1:0]);
		b.wbSel = wbSelT'(patMem[base+2][1:0]);
		b.regWrite = patMem[base+3][0];
		b.writeReg = patMem[base+4][regSelWidth-1:0];
		b.opA = patMem[base+5];
		b.opB = patMem[base+6];
		b.storeData = patMem[base+7];
		b.pc = patMem[base+8];
		b.halt = patMem[base+9][0];
		b.err = 1'b0;
		return b;
	endfunction

	function automatic expT makeExpect(input int line);
		expT e;
		int base;
		base = line * patCols;
		e.data = patMem[base+10];
		e.err = patMem[base+11][0];
		e.regWrite = patMem[base+3][0] & ~e.err; // a faulted op writes no register
		e.writeReg = patMem[base+4][regSelWidth-1:0];
		e.isMem = (patMem[base+1][1:0] != 2'd0) & ~e.err;
		return e;
	endfunction

	// ####################
	// writeback monitor
	always @(negedge clk) begin : watchWb
		expT e;
		if (!reset) begin
			if (dmemStall && memIssued == memRetired)
				failRun("dmemStall is high while no memory op is pending");
			if (busActive(axiReq) && memIssued == memRetired)
				failRun("an AXI valid or ready is high while no memory op is pending");
			if (wb.valid) begin
				if (retired >= issued) begin
					failRun("a writeback appeared with no instruction left to retire");
				end else begin
					e = expArr[retired];
					checkFlag("wb.err", wb.err, e.err);
					checkFlag("wb.regWrite", wb.regWrite, e.regWrite);
					checkReg("wb.writeReg", wb.writeReg, e.writeReg);
					if (!e.err) checkData("wb.data", wb.data, e.data); // undefined on a fault
					if (e.isMem) memRetired++;
					retired++;
				end
			end
		end
	end

	// ####################
	// stimulus
	initial begin
		int lineCount;
		int waited;
		logic pastHalt;
		expT nextExp;
		void'($urandom(32'hf950));
		reset = 1'b1;
		exIn = '0;
		$readmemh("verif/backEndPatterns.txt", patMem);
		lineCount = 0;
		while (lineCount < maxLines && patMem[lineCount*patCols] !== 16'h000f)
			lineCount++;
		if (lineCount == 0 || lineCount == maxLines)
			failRun("pattern file is missing, empty or has no end marker");

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checkFlag("wb.valid", wb.valid, 1'b0);
		checkFlag("dmemStall", dmemStall, 1'b0);
		checkFlag("axiReq valid/ready", busActive(axiReq), 1'b0);
		checkFlag("halted", halted, 1'b0);

		pastHalt = 1'b0;
		for (int i = 0; i < lineCount; i++) begin
			exIn = makeBundle(i);
			waited = 0;
			while (dmemStall) begin // hold the bundle until the stage takes it
				@(negedge clk);
				waited++;
				if (waited > stallLimit)
					failRun("a bundle was never accepted, dmemStall stayed high");
			end
			@(posedge clk);
			if (!pastHalt) begin
				nextExp = makeExpect(i);
				expArr[issued] = nextExp;
				issued++;
				if (nextExp.isMem) memIssued++;
			end
			pastHalt |= exIn.halt;
			@(negedge clk);
		end
		exIn = '0;

		waited = 0;
		while (retired != issued) begin
			@(negedge clk);
			waited++;
			if (waited > drainLimit)
				failRun($sformatf("timed out with %0d writebacks missing", issued - retired));
		end
		repeat (quietCycles) @(negedge clk); // lines after a halt stay silent
		checkFlag("halted", halted, pastHalt);
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* verif/backEndPatterns.txt */
// aluOp memOp wbSel regWrite writeReg opA opB storeData pc halt expData expErr
// alu 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 passB, mem 0 none 1 load 2 store, wb 0 alu 1 mem 2 link
0 0 0 1 1 0005 0003 0000 0000 0 0008 0
1 0 0 1 2 0003 0005 0000 0002 0 fffe 0
2 0 0 1 3 f0f0 ff00 0000 0004 0 f000 0
3 0 0 1 4 f0f0 0f0f 0000 0006 0 ffff 0
4 0 0 1 5 aaaa ffff 0000 0008 0 5555 0
5 0 0 1 6 0001 0014 0000 000a 0 0010 0
6 0 0 1 7 8000 000f 0000 000c 0 0001 0
7 0 0 1 1 ffff 0001 0000 000e 0 0001 0
7 0 0 1 2 0001 ffff 0000 0010 0 0000 0
8 0 0 0 3 1234 5678 0000 0012 0 5678 0
// store and load back, untouched word reads zero
0 2 0 0 0 0010 0004 beef 0014 0 0014 0
0 1 1 1 4 0010 0004 0000 0016 0 beef 0
0 1 1 1 5 0040 0000 0000 0018 0 0000 0
0 2 0 0 0 0100 0002 1357 001a 0 0102 0
8 1 1 1 6 0000 0102 0000 001c 0 1357 0
0 2 0 0 0 00fe 0000 abcd 001e 0 00fe 0
0 1 1 1 4 00fe 0000 0000 0020 0 abcd 0
// link writes pc plus 2
8 0 2 1 7 0000 0000 0000 0100 0 0102 0
// odd addresses fault
0 1 1 1 1 0021 0000 0000 0022 0 0000 1
0 2 0 0 2 0031 0000 dead 0024 0 0031 1
0 0 0 1 3 0007 0009 0000 0026 0 0010 0
// halt, the two lines after it never retire
0 0 0 1 5 0001 0001 0000 0028 1 0002 0
0 0 0 1 6 0002 0002 0000 002a 0 0004 0
0 2 0 0 0 0050 0000 ffff 002c 0 0050 0
// end marker
f

/* src.f */
src/pipePkg.sv
src/aluUnit.sv
src/exMemReg.sv
src/memAxiPort.sv
src/memWbReg.sv
src/backEnd.sv
verif/axiMemModel.sv
verif/backEndTb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module backEndTb -f src.f -o simv > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
